/* build.f */
axi_pkg.sv
axi_read_arbiter.sv
axi_read_router.sv
axi_write_sequencer.sv
axi_cache_bridge.sv
tb_axi_mem.sv
tb_axi_cache_bridge.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_axi_cache_bridge
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_axi_cache_bridge.sv */
module tb_axi_cache_bridge;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_cycles = 4000;

    logic clk = 1'b0;
    logic rst;
    logic ic_ar_valid, ic_ar_ready, ic_r_valid, ic_r_last;
    axi_pkg::id_t ic_ar_id, ic_r_id;
    axi_pkg::addr_t ic_ar_addr;
    axi_pkg::len_t ic_ar_len;
    axi_pkg::data_t ic_r_data;
    logic dc_ar_valid, dc_ar_ready, dc_r_valid, dc_r_last;
    axi_pkg::id_t dc_ar_id, dc_r_id, dc_aw_id, dc_b_id;
    axi_pkg::addr_t dc_ar_addr, dc_aw_addr;
    axi_pkg::len_t dc_ar_len, dc_aw_len;
    axi_pkg::data_t dc_r_data, dc_w_data;
    logic dc_aw_valid, dc_aw_ready, dc_w_valid, dc_w_ready, dc_b_valid;
    axi_pkg::strb_t dc_w_strb;
    axi_pkg::resp_t dc_b_resp;
    logic m_ar_valid, m_ar_ready, m_r_valid, m_r_ready, m_r_last;
    axi_pkg::id_t m_ar_id, m_r_id, m_aw_id, m_b_id;
    axi_pkg::addr_t m_ar_addr, m_aw_addr;
    axi_pkg::len_t m_ar_len, m_aw_len;
    axi_pkg::burst_t m_ar_burst, m_aw_burst;
    axi_pkg::size_t m_ar_size, m_aw_size;
    axi_pkg::data_t m_r_data, m_w_data;
    axi_pkg::resp_t m_r_resp, m_b_resp;
    logic m_aw_valid, m_aw_ready, m_w_valid, m_w_ready, m_w_last, m_b_valid, m_b_ready;
    axi_pkg::strb_t m_w_strb;

    logic [31:0]    lfsr = 32'h32084223;
    axi_pkg::data_t shadow [axi_pkg::addr_t];
    axi_pkg::data_t ic_exp [$];
    axi_pkg::data_t dc_exp [$];
    logic           ic_exp_last [$];
    logic           dc_exp_last [$];
    axi_pkg::addr_t ar_log [$];
    string          test_name = "reset";
    int errors = 0, checks = 0, cycles = 0;
    int ic_reads = 0, dc_reads = 0, writes = 0;
    int ic_readies = 0, dc_readies = 0, b_count = 0;
    int w_beats = 0;
    axi_pkg::len_t w_len = '0;
    axi_pkg::addr_t w_base = '0;

    axi_cache_bridge i_dut (.*);
    tb_axi_mem i_mem (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // expected word: pattern of the address unless written since
    function automatic axi_pkg::data_t ref_word(input axi_pkg::addr_t a);
        if (shadow.exists(a)) return shadow[a];
        return a ^ 32'h5a5a0000;
    endfunction

    function automatic void check_value(input string what, input logic [31:0] exp,
                                        input logic [31:0] got);
        checks++;
        assert (exp === got) else begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, got);
            errors++;
        end
    endfunction

    // ============================================================
    // comparison process, sampled mid-cycle
    // ============================================================
    always @(negedge clk) begin
        if (!rst) begin
            if (ic_r_valid) begin
                assert (ic_exp.size() != 0) else begin
                    $display("%s: unexpected beat on the icache read port", test_name);
                    errors++;
                end
                if (ic_exp.size() != 0) begin
                    check_value("ic data", ic_exp.pop_front(), ic_r_data);
                    check_value("ic last", 32'(ic_exp_last.pop_front()), 32'(ic_r_last));
                    check_value("ic id", 32'(ic_ar_id), 32'(ic_r_id));
                end
            end
            if (dc_r_valid) begin
                assert (dc_exp.size() != 0) else begin
                    $display("%s: unexpected beat on the dcache read port", test_name);
                    errors++;
                end
                if (dc_exp.size() != 0) begin
                    check_value("dc data", dc_exp.pop_front(), dc_r_data);
                    check_value("dc last", 32'(dc_exp_last.pop_front()), 32'(dc_r_last));
                    check_value("dc id", 32'(dc_ar_id), 32'(dc_r_id));
                end
            end
            if (m_r_valid) begin
                check_value("r ready", 1, 32'(m_r_ready));
            end
            if (ic_ar_ready) ic_readies++;
            if (dc_ar_ready) dc_readies++;
            if (m_ar_valid && m_ar_ready) begin
                ar_log.push_back(m_ar_addr);
                check_value("ar burst", 32'(axi_pkg::incr), 32'(m_ar_burst));
                check_value("ar size", 2, 32'(m_ar_size));   // 4 byte beats
            end
            if (m_aw_valid && m_aw_ready) begin
                w_beats = 0;
                check_value("aw addr", w_base, m_aw_addr);
                check_value("aw len", 32'(w_len), 32'(m_aw_len));
                check_value("aw id", 32'(dc_aw_id), 32'(m_aw_id));
                check_value("aw burst", 32'(axi_pkg::incr), 32'(m_aw_burst));
                check_value("aw size", 2, 32'(m_aw_size));
            end
            if (m_w_valid && m_w_ready) begin
                check_value("wlast", 32'(w_beats == int'(w_len)), 32'(m_w_last));
                check_value("w data", dc_w_data, m_w_data);
                check_value("w strb", 32'(dc_w_strb), 32'(m_w_strb));
                w_beats++;
            end
            if (dc_b_valid) begin
                b_count++;
                check_value("w beats", int'(w_len) + 1, w_beats);
                check_value("b resp", 32'(m_b_resp), 32'(dc_b_resp));
                check_value("b id", 32'(dc_aw_id), 32'(dc_b_id));
                check_value("b ready", 1, 32'(m_b_ready));
            end
        end
    end

    task automatic read_burst(input bit from_dc, input axi_pkg::addr_t a,
                              input axi_pkg::len_t l);
        bit got;
        for (int i = 0; i <= int'(l); i++) begin
            if (from_dc) begin
                dc_exp.push_back(ref_word(a + 32'(i * 4)));
                dc_exp_last.push_back(i == int'(l));
            end else begin
                ic_exp.push_back(ref_word(a + 32'(i * 4)));
                ic_exp_last.push_back(i == int'(l));
            end
        end
        if (from_dc) begin
            dc_reads++;
            dc_ar_valid = 1'b1;
            dc_ar_addr  = a;
            dc_ar_len   = l;
        end else begin
            ic_reads++;
            ic_ar_valid = 1'b1;
            ic_ar_addr  = a;
            ic_ar_len   = l;
        end
        do begin
            @(negedge clk);
            got = from_dc ? dc_ar_ready : ic_ar_ready;
            @(posedge clk);
            #1;
        end while (!got);
        if (from_dc) dc_ar_valid = 1'b0;
        else ic_ar_valid = 1'b0;
        while ((from_dc ? dc_exp.size() : ic_exp.size()) != 0) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic write_burst(input axi_pkg::addr_t a, input axi_pkg::len_t l);
        bit got;
        int b_before;
        b_before    = b_count;
        w_len       = l;
        w_base      = a;
        writes++;
        dc_aw_id    = axi_pkg::id_t'(take_bits(4));
        dc_aw_valid = 1'b1;
        dc_aw_addr  = a;
        dc_aw_len   = l;
        do begin
            @(negedge clk);
            got = dc_aw_ready;
            @(posedge clk);
            #1;
        end while (!got);
        dc_aw_valid = 1'b0;
        for (int i = 0; i <= int'(l); i++) begin
            dc_w_valid = 1'b1;
            dc_w_data  = take_bits(32);
            do begin
                @(negedge clk);
                got = dc_w_ready;
                @(posedge clk);
                #1;
            end while (!got);
            shadow[a + 32'(i * 4)] = dc_w_data;
            dc_w_valid = 1'b0;
        end
        while (b_count == b_before) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    // ============================================================
    // stimulus
    // ============================================================
    initial begin
        axi_pkg::addr_t a;
        rst = 1'b1;
        ic_ar_valid = 1'b0;
        ic_ar_id    = 4'd0;
        ic_ar_addr  = '0;
        ic_ar_len   = '0;
        dc_ar_valid = 1'b0;
        dc_ar_id    = 4'd1;
        dc_ar_addr  = '0;
        dc_ar_len   = '0;
        dc_aw_valid = 1'b0;
        dc_aw_id    = 4'd1;
        dc_aw_addr  = '0;
        dc_aw_len   = '0;
        dc_w_valid  = 1'b0;
        dc_w_data   = '0;
        dc_w_strb   = '1;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_value("idle valids", 0, 32'({m_ar_valid, m_aw_valid, m_w_valid}));
        check_value("idle ar_ready", 0, 32'({ic_ar_ready, dc_ar_ready}));
        check_value("idle aw_ready", 1, 32'(dc_aw_ready));
        @(posedge clk);
        #1;

        test_name = "ic single";
        read_burst(1'b0, 32'h0000_0100, 8'd0);
        test_name = "dc burst";
        read_burst(1'b1, 32'h0000_0200, 8'd7);

        test_name = "tie";
        ar_log.delete();
        fork
            read_burst(1'b0, 32'h0000_0300, 8'd1);
            read_burst(1'b1, 32'h0000_0400, 8'd2);
        join
        check_value("first ar addr", 32'h0000_0400, ar_log.size() != 0 ? ar_log[0] : '0);

        test_name = "write then read";
        write_burst(32'h0000_0500, 8'd3);
        read_burst(1'b1, 32'h0000_0500, 8'd3);

        test_name = "random mix";
        for (int n = 0; n < 40; n++) begin
            a = 32'h0000_1000 + (take_bits(6) << 2);
            case (take_bits(2))
                32'd0: read_burst(1'b0, a, axi_pkg::len_t'(take_bits(2)));
                32'd1: read_burst(1'b1, a, axi_pkg::len_t'(take_bits(2)));
                default: write_burst(a, axi_pkg::len_t'(take_bits(2)));
            endcase
        end

        test_name = "handshake counts";
        check_value("ic ar_ready pulses", ic_reads, ic_readies);
        check_value("dc ar_ready pulses", dc_reads, dc_readies);
        check_value("b responses", writes, b_count);

        $display("errors: %0d, checks: %0d, cycles: %0d", errors, checks, cycles);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* tb_axi_mem.sv */
module tb_axi_mem (
    input  logic              clk,
    input  logic              rst,
    input  logic              m_ar_valid,
    output logic              m_ar_ready,
    input  axi_pkg::id_t      m_ar_id,
    input  axi_pkg::addr_t    m_ar_addr,
    input  axi_pkg::len_t     m_ar_len,
    output logic              m_r_valid,
    output axi_pkg::data_t    m_r_data,
    output axi_pkg::id_t      m_r_id,
    output axi_pkg::resp_t    m_r_resp,
    output logic              m_r_last,
    input  logic              m_aw_valid,
    output logic              m_aw_ready,
    input  axi_pkg::addr_t    m_aw_addr,
    input  axi_pkg::id_t      m_aw_id,
    input  logic              m_w_valid,
    output logic              m_w_ready,
    input  axi_pkg::data_t    m_w_data,
    input  axi_pkg::strb_t    m_w_strb,
    input  logic              m_w_last,
    output logic              m_b_valid,
    output axi_pkg::id_t      m_b_id,
    output axi_pkg::resp_t    m_b_resp
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0]    lfsr = 32'h32084223;
    axi_pkg::data_t store [axi_pkg::addr_t];
    axi_pkg::id_t   ar_id_q [$];
    axi_pkg::addr_t ar_addr_q [$];
    axi_pkg::len_t  ar_len_q [$];
    logic           r_active = 1'b0;
    axi_pkg::addr_t r_addr;
    axi_pkg::len_t  r_left;
    axi_pkg::addr_t w_addr;
    axi_pkg::id_t   w_id;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic axi_pkg::data_t read_word(input axi_pkg::addr_t a);
        if (store.exists(a)) return store[a];
        return a ^ 32'h5a5a0000;               // untouched words
    endfunction

    // ============================================================
    // slave channels, sampled mid-cycle, driven 1 ns after the edge
    // ============================================================
    initial begin
        logic ar_hs, aw_hs, w_hs, w_end, r_hs, b_hs;
        axi_pkg::data_t wd;
        m_ar_ready = 1'b0;
        m_r_valid  = 1'b0;
        m_r_data   = '0;
        m_r_id     = '0;
        m_r_resp   = axi_pkg::okay;
        m_r_last   = 1'b0;
        m_aw_ready = 1'b0;
        m_w_ready  = 1'b0;
        m_b_valid  = 1'b0;
        m_b_id     = '0;
        m_b_resp   = axi_pkg::okay;
        forever begin
            @(negedge clk);
            ar_hs = m_ar_valid & m_ar_ready;
            aw_hs = m_aw_valid & m_aw_ready;
            w_hs  = m_w_valid & m_w_ready;
            w_end = w_hs & m_w_last;
            r_hs  = m_r_valid;                   // bridge always takes R
            b_hs  = m_b_valid;
            if (ar_hs) begin
                ar_id_q.push_back(m_ar_id);
                ar_addr_q.push_back(m_ar_addr);
                ar_len_q.push_back(m_ar_len);
            end
            if (aw_hs) begin
                w_addr = m_aw_addr;
                w_id   = m_aw_id;
            end
            if (w_hs) begin
                wd = read_word(w_addr);
                for (int i = 0; i < axi_pkg::strb_w; i++) begin
                    if (m_w_strb[i]) wd[8*i +: 8] = m_w_data[8*i +: 8];
                end
                store[w_addr] = wd;
                w_addr = w_addr + 32'd4;
            end
            @(posedge clk);
            #1;
            if (rst) begin
                r_active = 1'b0;
                m_ar_ready = 1'b0;
                m_aw_ready = 1'b0;
                m_w_ready  = 1'b0;
                m_r_valid  = 1'b0;
                m_b_valid  = 1'b0;
                ar_id_q.delete();
                ar_addr_q.delete();
                ar_len_q.delete();
            end else begin
                if (r_hs) begin
                    if (r_left == '0) begin
                        r_active = 1'b0;
                    end else begin
                        r_left = r_left - 8'd1;
                        r_addr = r_addr + 32'd4;
                    end
                end
                if (!r_active && ar_id_q.size() != 0) begin
                    r_active = 1'b1;
                    m_r_id   = ar_id_q.pop_front();
                    r_addr   = ar_addr_q.pop_front();
                    r_left   = ar_len_q.pop_front();
                end
                m_r_valid  = r_active;
                m_r_data   = read_word(r_addr);
                m_r_last   = (r_left == '0);
                m_b_valid  = w_end ? 1'b1 : (b_hs ? 1'b0 : m_b_valid);
                m_b_id     = w_id;
                if (w_end) begin
                    m_b_resp = axi_pkg::resp_t'(take_bits(2));  // any code, only forwarded
                end
                // roughly one stall in four on each ready
                m_ar_ready = (take_bits(2) != 32'd0);
                m_aw_ready = (take_bits(2) != 32'd0);
                m_w_ready  = (take_bits(2) != 32'd0);
            end
        end
    end

endmodule

/* axi_cache_bridge.sv */
module axi_cache_bridge #(
    parameter axi_pkg::id_t icache_id = axi_pkg::id_t'(0),
    parameter axi_pkg::id_t dcache_id = axi_pkg::id_t'(1)
) (
    input  logic              clk,
    input  logic              rst,
    // ============================================================
    // instruction cache side
    // ============================================================
    input  logic              ic_ar_valid,
    output logic              ic_ar_ready,
    input  axi_pkg::id_t      ic_ar_id,
    input  axi_pkg::addr_t    ic_ar_addr,
    input  axi_pkg::len_t     ic_ar_len,
    output logic              ic_r_valid,
    output axi_pkg::data_t    ic_r_data,
    output axi_pkg::id_t      ic_r_id,
    output logic              ic_r_last,
    // ============================================================
    // data cache side
    // ============================================================
    input  logic              dc_ar_valid,
    output logic              dc_ar_ready,
    input  axi_pkg::id_t      dc_ar_id,
    input  axi_pkg::addr_t    dc_ar_addr,
    input  axi_pkg::len_t     dc_ar_len,
    output logic              dc_r_valid,
    output axi_pkg::data_t    dc_r_data,
    output axi_pkg::id_t      dc_r_id,
    output logic              dc_r_last,
    input  logic              dc_aw_valid,
    output logic              dc_aw_ready,
    input  axi_pkg::id_t      dc_aw_id,
    input  axi_pkg::addr_t    dc_aw_addr,
    input  axi_pkg::len_t     dc_aw_len,
    input  logic              dc_w_valid,
    output logic              dc_w_ready,
    input  axi_pkg::data_t    dc_w_data,
    input  axi_pkg::strb_t    dc_w_strb,
    output logic              dc_b_valid,
    output axi_pkg::id_t      dc_b_id,
    output axi_pkg::resp_t    dc_b_resp,
    // ============================================================
    // AXI master port
    // ============================================================
    output logic              m_ar_valid,
    input  logic              m_ar_ready,
    output axi_pkg::id_t      m_ar_id,
    output axi_pkg::addr_t    m_ar_addr,
    output axi_pkg::len_t     m_ar_len,
    output axi_pkg::burst_t   m_ar_burst,
    output axi_pkg::size_t    m_ar_size,
    input  logic              m_r_valid,
    output logic              m_r_ready,
    input  axi_pkg::data_t    m_r_data,
    input  axi_pkg::id_t      m_r_id,
    input  axi_pkg::resp_t    m_r_resp,
    input  logic              m_r_last,
    output logic              m_aw_valid,
    input  logic              m_aw_ready,
    output axi_pkg::id_t      m_aw_id,
    output axi_pkg::addr_t    m_aw_addr,
    output axi_pkg::len_t     m_aw_len,
    output axi_pkg::burst_t   m_aw_burst,
    output axi_pkg::size_t    m_aw_size,
    output logic              m_w_valid,
    input  logic              m_w_ready,
    output axi_pkg::data_t    m_w_data,
    output axi_pkg::strb_t    m_w_strb,
    output logic              m_w_last,
    input  logic              m_b_valid,
    output logic              m_b_ready,
    input  axi_pkg::id_t      m_b_id,
    input  axi_pkg::resp_t    m_b_resp
);

    axi_read_arbiter i_read_arbiter (.*);

    axi_read_router #(
        .icache_id (icache_id),
        .dcache_id (dcache_id)
    ) i_read_router (.*);

    axi_write_sequencer i_write_sequencer (.*);

endmodule

/* axi_write_sequencer.sv */
module axi_write_sequencer (
    input  logic              clk,
    input  logic              rst,
    // data cache write address
    input  logic              dc_aw_valid,
    input  axi_pkg::id_t      dc_aw_id,
    input  axi_pkg::addr_t    dc_aw_addr,
    input  axi_pkg::len_t     dc_aw_len,
    output logic              dc_aw_ready,
    // data cache write data
    input  logic              dc_w_valid,
    input  axi_pkg::data_t    dc_w_data,
    input  axi_pkg::strb_t    dc_w_strb,
    output logic              dc_w_ready,
    // data cache write response
    output logic              dc_b_valid,
    output axi_pkg::id_t      dc_b_id,
    output axi_pkg::resp_t    dc_b_resp,
    // master AW channel
    output logic              m_aw_valid,
    output axi_pkg::id_t      m_aw_id,
    output axi_pkg::addr_t    m_aw_addr,
    output axi_pkg::len_t     m_aw_len,
    output axi_pkg::burst_t   m_aw_burst,
    output axi_pkg::size_t    m_aw_size,
    input  logic              m_aw_ready,
    // master W channel
    output logic              m_w_valid,
    output axi_pkg::data_t    m_w_data,
    output axi_pkg::strb_t    m_w_strb,
    output logic              m_w_last,
    input  logic              m_w_ready,
    // master B channel
    input  logic              m_b_valid,
    input  axi_pkg::id_t      m_b_id,
    input  axi_pkg::resp_t    m_b_resp,
    output logic              m_b_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data                               // data beats, then wait for B
    } state_t;

    state_t          state;
    axi_pkg::len_t   beats_left;
    logic            w_done;                  // last beat already sent
    logic            in_data;
    logic            w_fire;
    axi_pkg::id_t    aw_id;
    axi_pkg::addr_t  aw_addr;
    axi_pkg::len_t   aw_len;

    assign in_data = (state == st_data) & ~w_done;
    assign w_fire  = m_w_valid & m_w_ready;

    // ============================================================
    // burst FSM
    // ============================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= st_idle;
            beats_left <= '0;
            w_done     <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (dc_aw_valid) begin
                        state      <= st_addr;
                        beats_left <= dc_aw_len;
                    end
                end
                st_addr: begin
                    if (m_aw_ready) begin
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (w_fire) begin
                        if (m_w_last) begin
                            w_done <= 1'b1;
                        end else begin
                            beats_left <= beats_left - 1'b1;
                        end
                    end
                    if (m_b_valid & m_b_ready) begin
                        state  <= st_idle;  // burst closed by B
                        w_done <= 1'b0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && dc_aw_valid) begin
            aw_id   <= dc_aw_id;
            aw_addr <= dc_aw_addr;
            aw_len  <= dc_aw_len;
        end
    end

    assign dc_aw_ready = (state == st_idle);
    assign m_aw_valid  = (state == st_addr);
    assign m_aw_id     = aw_id;
    assign m_aw_addr   = aw_addr;
    assign m_aw_len    = aw_len;
    assign m_aw_burst  = axi_pkg::incr;
    assign m_aw_size   = axi_pkg::bus_size;

    // W passes straight through, last comes from our own count
    assign m_w_valid   = dc_w_valid & in_data;
    assign m_w_data    = dc_w_data;
    assign m_w_strb    = dc_w_strb;
    assign m_w_last    = (beats_left == '0);
    assign dc_w_ready  = m_w_ready & in_data;

    assign m_b_ready   = 1'b1;
    assign dc_b_valid  = m_b_valid;
    assign dc_b_id     = m_b_id;
    assign dc_b_resp   = m_b_resp;

    // ============================================================
    // checks
    // ============================================================
    a_w_after_last: assert property (@(posedge clk) disable iff (rst)
        w_fire && m_w_last |=> !m_w_valid until (m_b_valid && m_b_ready))
        else $error("w beat sent after wlast before b");

    a_b_after_last: assert property (@(posedge clk) disable iff (rst)
        m_b_valid |-> w_done && state == st_data)
        else $error("b response before the last w beat");

endmodule

/* axi_read_router.sv */
module axi_read_router #(
    parameter axi_pkg::id_t icache_id = axi_pkg::id_t'(0),
    parameter axi_pkg::id_t dcache_id = axi_pkg::id_t'(1)
) (
    // master R channel
    input  logic              m_r_valid,
    input  axi_pkg::data_t    m_r_data,
    input  axi_pkg::id_t      m_r_id,
    input  axi_pkg::resp_t    m_r_resp,
    input  logic              m_r_last,
    output logic              m_r_ready,
    // instruction cache read data
    output logic              ic_r_valid,
    output axi_pkg::data_t    ic_r_data,
    output axi_pkg::id_t      ic_r_id,
    output logic              ic_r_last,
    // data cache read data
    output logic              dc_r_valid,
    output axi_pkg::data_t    dc_r_data,
    output axi_pkg::id_t      dc_r_id,
    output logic              dc_r_last
);

    logic ic_hit;
    logic dc_hit;

    assign ic_hit = (m_r_id == icache_id);
    assign dc_hit = (m_r_id == dcache_id);

    // caches always take read data
    assign m_r_ready = 1'b1;

    // ============================================================
    // steering
    // ============================================================
    assign ic_r_valid = m_r_valid & ic_hit;
    assign dc_r_valid = m_r_valid & dc_hit;

    // payload fans out, only valid is steered
    assign ic_r_data  = m_r_data;
    assign ic_r_id    = m_r_id;
    assign ic_r_last  = m_r_last;

    assign dc_r_data  = m_r_data;
    assign dc_r_id    = m_r_id;
    assign dc_r_last  = m_r_last;

    // ============================================================
    // checks
    // ============================================================
    // every valid beat belongs to exactly one cache
    always_comb begin
        if (m_r_valid) begin
            a_id_match: assert final (ic_hit != dc_hit)
                else $error("r beat id %0h resp %0d matches no single cache",
                            m_r_id, m_r_resp);
        end
    end

endmodule

/* axi_read_arbiter.sv */
module axi_read_arbiter (
    input  logic              clk,
    input  logic              rst,
    // instruction cache read address
    input  logic              ic_ar_valid,
    input  axi_pkg::id_t      ic_ar_id,
    input  axi_pkg::addr_t    ic_ar_addr,
    input  axi_pkg::len_t     ic_ar_len,
    output logic              ic_ar_ready,
    // data cache read address
    input  logic              dc_ar_valid,
    input  axi_pkg::id_t      dc_ar_id,
    input  axi_pkg::addr_t    dc_ar_addr,
    input  axi_pkg::len_t     dc_ar_len,
    output logic              dc_ar_ready,
    // master AR channel
    output logic              m_ar_valid,
    output axi_pkg::id_t      m_ar_id,
    output axi_pkg::addr_t    m_ar_addr,
    output axi_pkg::len_t     m_ar_len,
    output axi_pkg::burst_t   m_ar_burst,
    output axi_pkg::size_t    m_ar_size,
    input  logic              m_ar_ready
);

    logic                 held_valid;
    axi_pkg::requester_t  owner;
    axi_pkg::ar_req_t     held;
    logic                 ar_end;

    assign ar_end = held_valid & m_ar_ready;  // bus handshake on AR

    // ============================================================
    // one-entry holding register
    // ============================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held_valid <= 1'b0;
            owner      <= axi_pkg::icache;
        end else if (!held_valid) begin
            if (dc_ar_valid) begin           // data cache wins ties
                held_valid <= 1'b1;
                owner      <= axi_pkg::dcache;
            end else if (ic_ar_valid) begin
                held_valid <= 1'b1;
                owner      <= axi_pkg::icache;
            end
        end else if (ar_end) begin
            held_valid <= 1'b0;              // idle again, capture next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (!held_valid) begin
            if (dc_ar_valid) begin
                held <= '{id: dc_ar_id, addr: dc_ar_addr, len: dc_ar_len,
                          burst: axi_pkg::incr};
            end else begin
                held <= '{id: ic_ar_id, addr: ic_ar_addr, len: ic_ar_len,
                          burst: axi_pkg::incr};
            end
        end
    end

    assign m_ar_valid  = held_valid;
    assign m_ar_id     = held.id;
    assign m_ar_addr   = held.addr;
    assign m_ar_len    = held.len;
    assign m_ar_burst  = held.burst;
    assign m_ar_size   = axi_pkg::bus_size;

    // ready goes back only to the owner, only on acceptance
    assign ic_ar_ready = ar_end & (owner == axi_pkg::icache);
    assign dc_ar_ready = ar_end & (owner == axi_pkg::dcache);

    // ============================================================
    // checks
    // ============================================================
    a_ar_stable: assert property (@(posedge clk) disable iff (rst)
        m_ar_valid && !m_ar_ready |=> m_ar_valid && $stable(held))
        else $error("ar request changed while stalled");

    // the pulse goes to the cache whose request is on the bus
    a_ic_ready_owner: assert property (@(posedge clk) disable iff (rst)
        ic_ar_ready |-> ic_ar_valid && m_ar_id == ic_ar_id && m_ar_addr == ic_ar_addr)
        else $error("icache ar_ready pulse for a request it does not hold");

    a_dc_ready_owner: assert property (@(posedge clk) disable iff (rst)
        dc_ar_ready |-> dc_ar_valid && m_ar_id == dc_ar_id && m_ar_addr == dc_ar_addr)
        else $error("dcache ar_ready pulse for a request it does not hold");

endmodule

/* axi_pkg.sv */
package axi_pkg;

    // ============================================================
    // bus geometry
    // ============================================================
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int id_w   = 4;
    localparam int len_w  = 8;              // beat count minus one
    localparam int strb_w = data_w / 8;
    localparam int size_w = 3;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] data_t;
    typedef logic [id_w-1:0]   id_t;
    typedef logic [len_w-1:0]  len_t;
    typedef logic [strb_w-1:0] strb_t;
    typedef logic [size_w-1:0] size_t;

    // every beat uses the full bus width
    localparam size_t bus_size = size_t'($clog2(strb_w));

    // ============================================================
    // channel encodings
    // ============================================================
    typedef enum logic [1:0] {
        fixed = 2'b00,
        incr  = 2'b01,
        wrap  = 2'b10
    } burst_t;

    typedef enum logic [1:0] {
        okay   = 2'b00,
        exokay = 2'b01,
        slverr = 2'b10,
        decerr = 2'b11
    } resp_t;

    typedef enum logic {
        icache = 1'b0,
        dcache = 1'b1
    } requester_t;

    // read address request as held toward the bus
    typedef struct packed {
        id_t    id;
        addr_t  addr;
        len_t   len;
        burst_t burst;
    } ar_req_t;

endpackage
